//--- include/mips_config.svh
// MIPS core configuration: boot vector, register file size and datapath widths
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// first instruction fetched after reset (kseg1 boot ROM)
`define MIPS_RESET_VECTOR 32'hBFC00000

// general purpose registers, register 0 reads as zero
`define MIPS_REG_COUNT 32

// data and address width
`define MIPS_XLEN 32

// width of a register index in the instruction word
`define MIPS_REG_ADDR_WIDTH 5

`endif

//--- verilog/mips_pkg.sv
// MIPS core package: instruction field encodings, ALU operations and the control word
package mips_pkg;

  // primary opcode, instr[31:26]
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_J       = 6'h02,
    OP_JAL     = 6'h03,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_ANDI    = 6'h0C,
    OP_ORI     = 6'h0D,
    OP_LUI     = 6'h0F,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2B
  } opcode_e;

  // function field of special instructions, instr[5:0]
  typedef enum logic [5:0] {
    F_SLL  = 6'h00,
    F_SRL  = 6'h02,
    F_JR   = 6'h08,
    F_ADDU = 6'h21,
    F_SUBU = 6'h23,
    F_AND  = 6'h24,
    F_OR   = 6'h25,
    F_XOR  = 6'h26,
    F_SLT  = 6'h2A,
    F_SLTU = 6'h2B
  } funct_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_LUI
  } alu_op_e;

  // destination register field, ra means register 31
  typedef enum logic [1:0] {DEST_RT, DEST_RD, DEST_RA} dest_sel_e;

  // write-back source
  typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_LINK} result_sel_e;

  typedef struct packed {
    logic        reg_write;
    dest_sel_e   dest_sel;
    logic        alu_src_imm;
    logic        imm_zero_ext;
    alu_op_e     alu_op;
    result_sel_e result_sel;
    logic        mem_read;
    logic        mem_write;
    logic        branch_eq;
    logic        branch_ne;
    logic        jump;
    logic        jump_reg;
  } ctrl_t;

endpackage

//--- verilog/regfile.sv
// Register file: 32 words, two combinational read ports, one clocked write port
`timescale 1ns/1ps
`include "mips_config.svh"

module regfile (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            write_enable,
  input  logic [`MIPS_REG_ADDR_WIDTH-1:0] read_addr1,
  input  logic [`MIPS_REG_ADDR_WIDTH-1:0] read_addr2,
  input  logic [`MIPS_REG_ADDR_WIDTH-1:0] write_addr,
  input  logic [`MIPS_XLEN-1:0]           write_data,
  output logic [`MIPS_XLEN-1:0]           read_data1,
  output logic [`MIPS_XLEN-1:0]           read_data2,
  output logic [`MIPS_XLEN-1:0]           register_v0
);

  logic [`MIPS_XLEN-1:0] regs [`MIPS_REG_COUNT];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && (write_addr != '0)) begin
      // writes to $zero are dropped
      regs[write_addr] <= write_data;
    end
  end

  // reads see the old value during a write cycle
  assign read_data1 = (read_addr1 != '0) ? regs[read_addr1] : '0;
  assign read_data2 = (read_addr2 != '0) ? regs[read_addr2] : '0;

  // v0 brought out for observation
  assign register_v0 = regs[2];

endmodule

//--- verilog/control_decoder.sv
// Control decoder: maps opcode and funct fields onto the datapath control word
`timescale 1ns/1ps

module control_decoder (
  input  logic [31:0]     instr,
  output mips_pkg::ctrl_t ctrl
);

  mips_pkg::opcode_e opcode;
  mips_pkg::funct_e  funct;

  assign opcode = mips_pkg::opcode_e'(instr[31:26]);
  assign funct  = mips_pkg::funct_e'(instr[5:0]);

  always_comb begin
    // default is a no-op with sequential flow
    ctrl.reg_write    = 1'b0;
    ctrl.dest_sel     = mips_pkg::DEST_RT;
    ctrl.alu_src_imm  = 1'b0;
    ctrl.imm_zero_ext = 1'b0;
    ctrl.alu_op       = mips_pkg::ALU_ADD;
    ctrl.result_sel   = mips_pkg::RES_ALU;
    ctrl.mem_read     = 1'b0;
    ctrl.mem_write    = 1'b0;
    ctrl.branch_eq    = 1'b0;
    ctrl.branch_ne    = 1'b0;
    ctrl.jump         = 1'b0;
    ctrl.jump_reg     = 1'b0;

    case (opcode)
      mips_pkg::OP_SPECIAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.dest_sel  = mips_pkg::DEST_RD;
        case (funct)
          mips_pkg::F_ADDU: ctrl.alu_op = mips_pkg::ALU_ADD;
          mips_pkg::F_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
          mips_pkg::F_AND:  ctrl.alu_op = mips_pkg::ALU_AND;
          mips_pkg::F_OR:   ctrl.alu_op = mips_pkg::ALU_OR;
          mips_pkg::F_XOR:  ctrl.alu_op = mips_pkg::ALU_XOR;
          mips_pkg::F_SLT:  ctrl.alu_op = mips_pkg::ALU_SLT;
          mips_pkg::F_SLTU: ctrl.alu_op = mips_pkg::ALU_SLTU;
          mips_pkg::F_SLL:  ctrl.alu_op = mips_pkg::ALU_SLL;
          mips_pkg::F_SRL:  ctrl.alu_op = mips_pkg::ALU_SRL;
          mips_pkg::F_JR: begin
            ctrl.reg_write = 1'b0;
            ctrl.jump_reg  = 1'b1;
          end
          default: ctrl.reg_write = 1'b0;
        endcase
      end
      mips_pkg::OP_J: ctrl.jump = 1'b1;
      mips_pkg::OP_JAL: begin
        // link address goes to $ra
        ctrl.jump       = 1'b1;
        ctrl.reg_write  = 1'b1;
        ctrl.dest_sel   = mips_pkg::DEST_RA;
        ctrl.result_sel = mips_pkg::RES_LINK;
      end
      mips_pkg::OP_BEQ: begin
        ctrl.branch_eq = 1'b1;
        ctrl.alu_op    = mips_pkg::ALU_SUB;
      end
      mips_pkg::OP_BNE: begin
        ctrl.branch_ne = 1'b1;
        ctrl.alu_op    = mips_pkg::ALU_SUB;
      end
      mips_pkg::OP_ADDIU, mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_LUI: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        // logical immediates are zero extended
        ctrl.imm_zero_ext = (opcode == mips_pkg::OP_ANDI) || (opcode == mips_pkg::OP_ORI);
        case (opcode)
          mips_pkg::OP_ANDI: ctrl.alu_op = mips_pkg::ALU_AND;
          mips_pkg::OP_ORI:  ctrl.alu_op = mips_pkg::ALU_OR;
          mips_pkg::OP_LUI:  ctrl.alu_op = mips_pkg::ALU_LUI;
          default:           ctrl.alu_op = mips_pkg::ALU_ADD;
        endcase
      end
      mips_pkg::OP_LW: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.result_sel  = mips_pkg::RES_MEM;
        ctrl.mem_read    = 1'b1;
      end
      mips_pkg::OP_SW: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

//--- verilog/alu.sv
// ALU: add, subtract, logic, compare, shift and load-upper operations
`timescale 1ns/1ps
`include "mips_config.svh"

module alu (
  input  mips_pkg::alu_op_e     op,
  input  logic [`MIPS_XLEN-1:0] a,
  input  logic [`MIPS_XLEN-1:0] b,
  input  logic [4:0]            shamt,
  output logic [`MIPS_XLEN-1:0] result,
  output logic                  zero
);

  logic [`MIPS_XLEN-1:0] diff;

  // shared by sub and the branch compare
  assign diff = a - b;

  always_comb begin
    case (op)
      mips_pkg::ALU_ADD:  result = a + b;
      mips_pkg::ALU_SUB:  result = diff;
      mips_pkg::ALU_AND:  result = a & b;
      mips_pkg::ALU_OR:   result = a | b;
      mips_pkg::ALU_XOR:  result = a ^ b;
      mips_pkg::ALU_SLT: begin
        result = {{(`MIPS_XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
      end
      mips_pkg::ALU_SLTU: begin
        result = {{(`MIPS_XLEN-1){1'b0}}, (a < b)};
      end
      // shifts act on rt, the b operand
      mips_pkg::ALU_SLL:  result = b << shamt;
      mips_pkg::ALU_SRL:  result = b >> shamt;
      mips_pkg::ALU_LUI:  result = {b[15:0], 16'h0000};
      default:            result = '0;
    endcase
  end

  // beq and bne test rs == rt
  assign zero = (diff == '0);

endmodule

//--- verilog/pc_unit.sv
// PC unit: program counter with boot vector, stall, next-address select and halt
`timescale 1ns/1ps
`include "mips_config.svh"

module pc_unit (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  clk_enable,
  input  mips_pkg::ctrl_t       ctrl,
  input  logic                  zero,
  input  logic [`MIPS_XLEN-1:0] imm_ext,
  input  logic [25:0]           jump_index,
  input  logic [`MIPS_XLEN-1:0] jump_reg_target,
  output logic [`MIPS_XLEN-1:0] pc,
  output logic [`MIPS_XLEN-1:0] pc_plus4,
  output logic                  active
);

  logic [`MIPS_XLEN-1:0] branch_target;
  logic [`MIPS_XLEN-1:0] jump_target;
  logic [`MIPS_XLEN-1:0] next_pc;
  logic                  take_branch;
  logic                  halt;

  assign pc_plus4      = pc + 32'd4;
  assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};
  // jump stays in the current 256MB region
  assign jump_target   = {pc_plus4[31:28], jump_index, 2'b00};

  assign take_branch = (ctrl.branch_eq && zero) || (ctrl.branch_ne && !zero);

  // jr $zero ends the program
  assign halt = ctrl.jump_reg && (jump_reg_target == '0);

  always_comb begin
    if (ctrl.jump_reg) begin
      next_pc = jump_reg_target;
    end else if (ctrl.jump) begin
      next_pc = jump_target;
    end else if (take_branch) begin
      next_pc = branch_target;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc     <= `MIPS_RESET_VECTOR;
      active <= 1'b1;
    end else if (clk_enable && active) begin
      if (halt) begin
        // pc stays on the jr, core sleeps until reset
        active <= 1'b0;
      end else begin
        pc <= next_pc;
      end
    end
  end

endmodule

//--- verilog/mips_core.sv
// MIPS core top: single-cycle datapath joining decoder, register file, ALU and PC unit
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_core (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  clk_enable,
  output logic                  active,
  output logic [`MIPS_XLEN-1:0] register_v0,

  // instruction port, read returned combinationally
  output logic [`MIPS_XLEN-1:0] instr_address,
  input  logic [`MIPS_XLEN-1:0] instr_readdata,

  // data port
  output logic [`MIPS_XLEN-1:0] data_address,
  output logic [`MIPS_XLEN-1:0] data_writedata,
  output logic                  data_write,
  output logic                  data_read,
  input  logic [`MIPS_XLEN-1:0] data_readdata
);

  mips_pkg::ctrl_t ctrl;

  logic [`MIPS_XLEN-1:0]           instr;
  logic [`MIPS_REG_ADDR_WIDTH-1:0] rs;
  logic [`MIPS_REG_ADDR_WIDTH-1:0] rt;
  logic [`MIPS_REG_ADDR_WIDTH-1:0] rd;
  logic [`MIPS_REG_ADDR_WIDTH-1:0] dest_addr;
  logic [15:0]                     imm;
  logic [`MIPS_XLEN-1:0]           imm_ext;
  logic [`MIPS_XLEN-1:0]           rs_data;
  logic [`MIPS_XLEN-1:0]           rt_data;
  logic [`MIPS_XLEN-1:0]           alu_b;
  logic [`MIPS_XLEN-1:0]           alu_result;
  logic                            alu_zero;
  logic [`MIPS_XLEN-1:0]           write_back;
  logic [`MIPS_XLEN-1:0]           pc;
  logic [`MIPS_XLEN-1:0]           pc_plus4;
  logic                            commit;

  assign instr_address = pc;
  assign instr         = instr_readdata;

  assign rs  = instr[25:21];
  assign rt  = instr[20:16];
  assign rd  = instr[15:11];
  assign imm = instr[15:0];

  control_decoder u_decoder (
    .instr (instr),
    .ctrl  (ctrl)
  );

  // an instruction retires only on an enabled edge of a running core
  assign commit = clk_enable && active;

  always_comb begin
    case (ctrl.dest_sel)
      mips_pkg::DEST_RD: dest_addr = rd;
      mips_pkg::DEST_RA: dest_addr = 5'd31;
      default:           dest_addr = rt;
    endcase
  end

  always_comb begin
    case (ctrl.result_sel)
      mips_pkg::RES_MEM:  write_back = data_readdata;
      mips_pkg::RES_LINK: write_back = pc_plus4;
      default:            write_back = alu_result;
    endcase
  end

  regfile u_regfile (
    .clk          (clk),
    .reset        (reset),
    .write_enable (ctrl.reg_write && commit),
    .read_addr1   (rs),
    .read_addr2   (rt),
    .write_addr   (dest_addr),
    .write_data   (write_back),
    .read_data1   (rs_data),
    .read_data2   (rt_data),
    .register_v0  (register_v0)
  );

  // andi and ori take a zero-extended immediate
  assign imm_ext = ctrl.imm_zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};
  assign alu_b   = ctrl.alu_src_imm ? imm_ext : rt_data;

  alu u_alu (
    .op     (ctrl.alu_op),
    .a      (rs_data),
    .b      (alu_b),
    .shamt  (instr[10:6]),
    .result (alu_result),
    .zero   (alu_zero)
  );

  pc_unit u_pc_unit (
    .clk             (clk),
    .reset           (reset),
    .clk_enable      (clk_enable),
    .ctrl            (ctrl),
    .zero            (alu_zero),
    .imm_ext         (imm_ext),
    .jump_index      (instr[25:0]),
    .jump_reg_target (rs_data),
    .pc              (pc),
    .pc_plus4        (pc_plus4),
    .active          (active)
  );

  assign data_address   = alu_result;
  assign data_writedata = rt_data;
  assign data_write     = ctrl.mem_write && commit;
  assign data_read      = ctrl.mem_read && active;

endmodule

//--- testbench/tb_mips_core.sv
// Testbench for mips_core: memories, program generator, instruction-set model and checks
`timescale 1ns/1ps
`include "mips_config.svh"

module tb_mips_core;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 8;
  localparam int RAND_LEN     = 41;
  localparam int FLOW_LEN     = 16;
  localparam int RUNS         = 4;
  localparam int TOTAL_INSTR  = 3 * RAND_LEN + FLOW_LEN;
  // reset, 10 post-halt cycles and some slack per run
  localparam int WATCHDOG_CYCLES = TOTAL_INSTR * 3 + RUNS * (RESET_CYCLES + 14);

  typedef struct packed {
    logic [31:0] pc;
    logic        write;
    logic        read;
    logic [31:0] addr;
    logic [31:0] wdata;
  } step_t;

  logic        clk;
  logic        reset;
  logic        clk_enable;
  logic        active;
  logic [31:0] register_v0;
  logic [31:0] instr_address;
  logic [31:0] instr_readdata;
  logic [31:0] data_address;
  logic [31:0] data_writedata;
  logic        data_write;
  logic        data_read;
  logic [31:0] data_readdata;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] imem_off;
  logic        fill_req;
  logic        checking;
  logic        stall_mode;

  // instruction-set model state
  logic [31:0] ref_regs [32];
  logic [31:0] ref_dmem [256];
  logic [31:0] ref_pc;
  logic        ref_halted;
  logic [31:0] lcg_state = 32'd54;

  mips_core dut (
    .clk            (clk),
    .reset          (reset),
    .clk_enable     (clk_enable),
    .active         (active),
    .register_v0    (register_v0),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_writedata (data_writedata),
    .data_write     (data_write),
    .data_read      (data_read),
    .data_readdata  (data_readdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // instruction memory starts at the boot vector, outside it reads as nop
  assign imem_off       = instr_address - `MIPS_RESET_VECTOR;
  assign instr_readdata = (imem_off < 32'd1024) ? imem[imem_off[9:2]] : 32'h0;
  assign data_readdata  = dmem[data_address[9:2]];

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [31:0] fill_word(input int i);
    logic [31:0] w;
    w = 32'(i);
    return (w * 32'h0101_0101) ^ 32'h5A3C_96E1 ^ (w << 20);
  endfunction

  always @(posedge clk) begin
    if (fill_req) begin
      for (int i = 0; i < 256; i++) begin
        dmem[i] <= fill_word(i);
      end
    end else if (data_write && clk_enable) begin
      dmem[data_address[9:2]] <= data_writedata;
    end
  end

  // stall pattern from the LCG, one cycle in four on average
  always @(posedge clk) begin
    logic [31:0] r;
    logic        stall_now;
    stall_now = stall_mode;
    #1;
    if (stall_now) begin
      r = lcg_next();
      clk_enable = (r[17:16] != 2'b00);
    end else begin
      clk_enable = 1'b1;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("Fail %s expected %h actual %h", name, exp, act);
    $display("Regression failed");
    $fatal(1, "value mismatch");
  endtask

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "check failed");
  endtask

  function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [4:0] rd,
                                        input logic [4:0] sh);
    return {6'h00, rs, rt, rd, sh, funct};
  endfunction

  function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] word_addr(input int k);
    return `MIPS_RESET_VECTOR + 32'(4 * k);
  endfunction

  function automatic void set_reg(input logic [4:0] d, input logic [31:0] v);
    if (d != 5'd0) ref_regs[d] = v;
  endfunction

  // executes the instruction at ref_pc and returns what the bus should show
  function automatic step_t ref_step();
    step_t       s;
    logic [31:0] ins, a, b, sx, zx, ea, t, off;
    logic [4:0]  rs, rt, rd;
    off = ref_pc - `MIPS_RESET_VECTOR;
    ins = (off < 32'd1024) ? imem[off[9:2]] : 32'h0;
    rs  = ins[25:21];
    rt  = ins[20:16];
    rd  = ins[15:11];
    a   = ref_regs[rs];
    b   = ref_regs[rt];
    sx  = {{16{ins[15]}}, ins[15:0]};
    zx  = {16'h0000, ins[15:0]};
    ea  = a + sx;
    t   = ref_pc + 32'd4;
    s   = '0;
    s.pc = ref_pc;
    case (ins[31:26])
      6'h00: begin
        case (ins[5:0])
          6'h21: set_reg(rd, a + b);
          6'h23: set_reg(rd, a - b);
          6'h24: set_reg(rd, a & b);
          6'h25: set_reg(rd, a | b);
          6'h26: set_reg(rd, a ^ b);
          6'h2A: set_reg(rd, {31'b0, $signed(a) < $signed(b)});
          6'h2B: set_reg(rd, {31'b0, a < b});
          6'h00: set_reg(rd, b << ins[10:6]);
          6'h02: set_reg(rd, b >> ins[10:6]);
          6'h08: begin
            if (a == 32'h0) begin
              ref_halted = 1'b1;
              t = ref_pc;
            end else begin
              t = a;
            end
          end
          default: ;
        endcase
      end
      6'h02: t = {t[31:28], ins[25:0], 2'b00};
      6'h03: begin
        set_reg(5'd31, t);
        t = {t[31:28], ins[25:0], 2'b00};
      end
      6'h04: if (a == b) t = t + {sx[29:0], 2'b00};
      6'h05: if (a != b) t = t + {sx[29:0], 2'b00};
      6'h09: set_reg(rt, a + sx);
      6'h0C: set_reg(rt, a & zx);
      6'h0D: set_reg(rt, a | zx);
      6'h0F: set_reg(rt, {ins[15:0], 16'h0000});
      6'h23: begin
        s.read = 1'b1;
        s.addr = ea;
        set_reg(rt, ref_dmem[ea[9:2]]);
      end
      6'h2B: begin
        s.write = 1'b1;
        s.addr  = ea;
        s.wdata = b;
        ref_dmem[ea[9:2]] = b;
      end
      default: ;
    endcase
    ref_pc = t;
    return s;
  endfunction

  // compare process, samples at the falling edge where outputs are settled
  always @(negedge clk) begin
    step_t e;
    if (checking && !reset) begin
      assert (register_v0 == ref_regs[2])
        else report_mismatch("register_v0", ref_regs[2], register_v0);
      if (clk_enable && active) begin
        e = ref_step();
        assert (instr_address == e.pc)
          else report_mismatch("instr_address", e.pc, instr_address);
        assert (data_write == e.write)
          else report_mismatch("data_write", {31'b0, e.write}, {31'b0, data_write});
        assert (data_read == e.read)
          else report_mismatch("data_read", {31'b0, e.read}, {31'b0, data_read});
        if (e.write || e.read) begin
          assert (data_address == e.addr)
            else report_mismatch("data_address", e.addr, data_address);
        end
        if (e.write) begin
          assert (data_writedata == e.wdata)
            else report_mismatch("data_writedata", e.wdata, data_writedata);
        end
      end else if (!clk_enable) begin
        assert (!data_write) else report_error("data_write went high during a stall");
        assert (instr_address == ref_pc)
          else report_mismatch("instr_address", ref_pc, instr_address);
      end
    end
  end

  task automatic gen_random(input int len, input bit with_mem);
    logic [31:0] r, r2;
    logic [4:0]  rs, rt, rd;
    int          kind;
    for (int i = 0; i < 256; i++) imem[i] = 32'h0;
    for (int k = 0; k < len; k++) begin
      r    = lcg_next();
      r2   = lcg_next();
      // registers 0 to 7 so that v0 and $zero are hit often
      rs   = {2'b00, r[18:16]};
      rt   = {2'b00, r[21:19]};
      rd   = {2'b00, r[24:22]};
      kind = int'(r[30:25]) % (with_mem ? 15 : 13);
      case (kind)
        0:  imem[k] = enc_r(6'h21, rs, rt, rd, 5'd0);
        1:  imem[k] = enc_r(6'h23, rs, rt, rd, 5'd0);
        2:  imem[k] = enc_r(6'h24, rs, rt, rd, 5'd0);
        3:  imem[k] = enc_r(6'h25, rs, rt, rd, 5'd0);
        4:  imem[k] = enc_r(6'h26, rs, rt, rd, 5'd0);
        5:  imem[k] = enc_r(6'h2A, rs, rt, rd, 5'd0);
        6:  imem[k] = enc_r(6'h2B, rs, rt, rd, 5'd0);
        7:  imem[k] = enc_r(6'h00, 5'd0, rt, rd, r2[20:16]);
        8:  imem[k] = enc_r(6'h02, 5'd0, rt, rd, r2[20:16]);
        9:  imem[k] = enc_i(6'h09, rs, rt, r2[31:16]);
        10: imem[k] = enc_i(6'h0C, rs, rt, r2[31:16]);
        11: imem[k] = enc_i(6'h0D, rs, rt, r2[31:16]);
        12: imem[k] = enc_i(6'h0F, 5'd0, rt, r2[31:16]);
        13: imem[k] = enc_i(6'h2B, 5'd0, rt, {6'b0, r2[23:16], 2'b00});
        default: imem[k] = enc_i(6'h23, 5'd0, rt, {6'b0, r2[23:16], 2'b00});
      endcase
    end
    imem[len] = enc_r(6'h08, 5'd0, 5'd0, 5'd0, 5'd0);
  endtask

  // taken and not-taken branches, j, jal and a return through jr $ra
  task automatic gen_control_flow();
    logic [31:0] j_target;
    logic [31:0] jal_target;
    j_target   = word_addr(11);
    jal_target = word_addr(14);
    for (int i = 0; i < 256; i++) imem[i] = 32'h0;
    imem[0]  = enc_i(6'h09, 5'd0, 5'd8, 16'd5);
    imem[1]  = enc_i(6'h09, 5'd0, 5'd9, 16'd5);
    imem[2]  = enc_i(6'h04, 5'd8, 5'd9, 16'd1);
    imem[3]  = enc_i(6'h09, 5'd0, 5'd2, 16'h0111);
    imem[4]  = enc_i(6'h05, 5'd8, 5'd9, 16'd1);
    imem[5]  = enc_i(6'h09, 5'd9, 5'd9, 16'd1);
    imem[6]  = enc_i(6'h05, 5'd8, 5'd9, 16'd1);
    imem[7]  = enc_i(6'h09, 5'd0, 5'd2, 16'h0222);
    imem[8]  = enc_i(6'h04, 5'd8, 5'd9, 16'd1);
    imem[9]  = {6'h02, j_target[27:2]};
    imem[10] = enc_i(6'h09, 5'd0, 5'd2, 16'h0333);
    imem[11] = {6'h03, jal_target[27:2]};
    imem[12] = enc_r(6'h21, 5'd31, 5'd0, 5'd2, 5'd0);
    imem[13] = enc_r(6'h08, 5'd0, 5'd0, 5'd0, 5'd0);
    imem[14] = enc_i(6'h09, 5'd0, 5'd10, 16'd7);
    imem[15] = enc_r(6'h08, 5'd31, 5'd0, 5'd0, 5'd0);
  endtask

  task automatic run_program(input bit stalls);
    logic [31:0] hold_pc, hold_v0;
    for (int i = 0; i < 32; i++) ref_regs[i] = 32'h0;
    for (int i = 0; i < 256; i++) ref_dmem[i] = fill_word(i);
    ref_pc     = `MIPS_RESET_VECTOR;
    ref_halted = 1'b0;
    @(posedge clk);
    #1;
    reset    = 1'b1;
    fill_req = 1'b1;
    @(posedge clk);
    #1;
    fill_req = 1'b0;
    repeat (RESET_CYCLES - 1) @(posedge clk);
    #1;
    reset = 1'b0;
    assert (instr_address == `MIPS_RESET_VECTOR)
      else report_mismatch("instr_address", `MIPS_RESET_VECTOR, instr_address);
    assert (active) else report_error("active is low after reset");
    assert (register_v0 == 32'h0) else report_mismatch("register_v0", 32'h0, register_v0);
    checking   = 1'b1;
    stall_mode = stalls;
    while (active) @(negedge clk);
    checking   = 1'b0;
    stall_mode = 1'b0;
    assert (ref_halted) else report_error("core halted before the model reached jr $zero");
    assert (register_v0 == ref_regs[2])
      else report_mismatch("register_v0", ref_regs[2], register_v0);
    hold_pc = instr_address;
    hold_v0 = register_v0;
    repeat (10) begin
      @(negedge clk);
      assert (!active) else report_error("active rose again after halt");
      assert (instr_address == hold_pc)
        else report_mismatch("instr_address", hold_pc, instr_address);
      assert (register_v0 == hold_v0)
        else report_mismatch("register_v0", hold_v0, register_v0);
      assert (!data_write) else report_error("data_write went high after halt");
    end
  endtask

  initial begin
    reset      = 1'b1;
    clk_enable = 1'b1;
    fill_req   = 1'b0;
    checking   = 1'b0;
    stall_mode = 1'b0;
    gen_random(RAND_LEN - 1, 1'b0);
    run_program(1'b0);
    gen_random(RAND_LEN - 1, 1'b1);
    run_program(1'b0);
    gen_control_flow();
    run_program(1'b0);
    // v0 holds the jal link address
    assert (register_v0 == word_addr(12))
      else report_mismatch("register_v0", word_addr(12), register_v0);
    gen_random(RAND_LEN - 1, 1'b1);
    run_program(1'b1);
    $display("Regression passed");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    if (active) begin
      $display("Timeout, the core was still running when the time limit ran out");
    end else begin
      $display("Timeout, the test sequence did not finish in time");
    end
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- all.f
+incdir+include
verilog/mips_pkg.sv
verilog/regfile.sv
verilog/control_decoder.sv
verilog/alu.sv
verilog/pc_unit.sv
verilog/mips_core.sv
testbench/tb_mips_core.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the mips_core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  -f all.f \
  --top-module tb_mips_core \
  -o sim_tb_mips_core

# the simulator exits non-zero on $fatal, the log decides the result
./obj_dir/sim_tb_mips_core > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log; then
  exit 1
fi
if ! grep -q "Regression passed" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0
